// File: rtl/command_decoder.sv
/* command decoder
   turns received bytes into framebuffer writes and holds the channel and plane enables */
`timescale 1ns/100ps
module command_decoder #(
    parameter int BRIGHTNESS_LEVELS = led_matrix_pkg::BRIGHTNESS_LEVELS
) (
    input  logic                          clk_root,
    input  logic                          arst_n,
    input  logic [7:0]                    rx_byte,
    input  logic                          rx_valid,
    output led_matrix_pkg::fb_write_t     fb_write,
    output logic [2:0]                    rgb_enable,
    output logic [BRIGHTNESS_LEVELS-1:0]  brightness_enable
);
    import led_matrix_pkg::*;

    typedef enum logic [2:0] {
        ST_CMD,
        ST_PIX_ADDR,
        ST_PIX_RED,
        ST_PIX_GB,
        ST_RGB_EN,
        ST_PLANE_EN
    } dec_state_t;

    dec_state_t       state;
    logic             wr_valid;
    logic [ROW_W:0]   wr_row;
    logic [COL_W-1:0] wr_col;
    pixel_t           wr_pix;

    assign fb_write = '{valid: wr_valid, row: wr_row, column: wr_col, pixel: wr_pix};

    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            state             <= ST_CMD;
            wr_valid          <= 1'b0;
            rgb_enable        <= 3'b111;
            brightness_enable <= '1;
        end else begin
            wr_valid <= 1'b0;
            if (rx_valid) begin
                case (state)
                    ST_CMD: begin
                        case (rx_byte)
                            CMD_PIXEL:        state <= ST_PIX_ADDR;
                            CMD_RGB_ENABLE:   state <= ST_RGB_EN;
                            CMD_PLANE_ENABLE: state <= ST_PLANE_EN;
                            default:          state <= ST_CMD; // stray byte
                        endcase
                    end
                    ST_PIX_ADDR: state <= ST_PIX_RED;
                    ST_PIX_RED:  state <= ST_PIX_GB;
                    ST_PIX_GB: begin
                        wr_valid <= 1'b1; // last operand in
                        state    <= ST_CMD;
                    end
                    ST_RGB_EN: begin
                        rgb_enable <= rx_byte[2:0];
                        state      <= ST_CMD;
                    end
                    ST_PLANE_EN: begin
                        brightness_enable <= rx_byte[BRIGHTNESS_LEVELS-1:0];
                        state             <= ST_CMD;
                    end
                    default: state <= ST_CMD;
                endcase
            end
        end
    end

    // operands land straight in the write word
    always_ff @(posedge clk_root) begin
        if (rx_valid) begin
            case (state)
                ST_PIX_ADDR: begin
                    wr_row <= rx_byte[6:4];
                    wr_col <= rx_byte[3:0];
                end
                ST_PIX_RED: wr_pix.red <= rx_byte[3:0];
                ST_PIX_GB: begin
                    wr_pix.green <= rx_byte[7:4];
                    wr_pix.blue  <= rx_byte[3:0];
                end
                default: ;
            endcase
        end
    end

endmodule

// File: rtl/framebuffer_bank.sv
/* framebuffer bank
   pixel memory for one panel half with a registered read port */
`timescale 1ns/100ps
module framebuffer_bank #(
    parameter bit BANK              = 1'b0,
    parameter int PANEL_WIDTH       = led_matrix_pkg::PANEL_WIDTH,
    parameter int PANEL_HALF_HEIGHT = led_matrix_pkg::PANEL_HALF_HEIGHT
) (
    input  logic                                                    clk_root,
    input  led_matrix_pkg::fb_write_t                               fb_write,
    input  logic [$clog2(PANEL_HALF_HEIGHT)+$clog2(PANEL_WIDTH)-1:0] rd_addr,
    output led_matrix_pkg::pixel_t                                  rd_data
);
    import led_matrix_pkg::*;

    localparam int ROW_BITS = $clog2(PANEL_HALF_HEIGHT);
    localparam int COL_BITS = $clog2(PANEL_WIDTH);
    localparam int DEPTH    = PANEL_WIDTH * PANEL_HALF_HEIGHT;

    pixel_t                     mem [DEPTH];
    logic [ROW_BITS+COL_BITS-1:0] wr_addr;
    logic                       wr_en;

    assign wr_addr = {fb_write.row[ROW_BITS-1:0], fb_write.column[COL_BITS-1:0]};
    assign wr_en   = fb_write.valid && (fb_write.row[ROW_W] == BANK); // only our half

    always_ff @(posedge clk_root) begin
        if (wr_en) mem[wr_addr] <= fb_write.pixel;
        rd_data <= mem[rd_addr];
    end

endmodule

// File: rtl/framebuffer_fetch.sv
/* framebuffer fetch
   reads the scanned column from both banks and picks the bits of the current plane */
`timescale 1ns/100ps
module framebuffer_fetch #(
    parameter int BRIGHTNESS_LEVELS = led_matrix_pkg::BRIGHTNESS_LEVELS
) (
    input  logic                              clk_root,
    input  logic                              arst_n,
    input  led_matrix_pkg::scan_pos_t         scan_pos,
    input  logic                              shift_tick,
    output logic [led_matrix_pkg::ADDR_W-1:0] rd_addr,
    input  led_matrix_pkg::pixel_t            rd_data_top,
    input  led_matrix_pkg::pixel_t            rd_data_bottom,
    input  logic [2:0]                        rgb_enable,
    input  logic [BRIGHTNESS_LEVELS-1:0]      brightness_enable,
    output led_matrix_pkg::rgb_t              rgb_top,
    output led_matrix_pkg::rgb_t              rgb_bottom
);
    import led_matrix_pkg::*;

    logic       data_ready; // bank data for the column is out
    logic [2:0] chan_mask;

    // one bit of each channel, masked per channel
    function automatic rgb_t plane_bits(pixel_t px, logic [PLANE_W-1:0] plane,
                                        logic [2:0] mask);
        rgb_t bits;
        bits.r = px.red[plane] & mask[2];
        bits.g = px.green[plane] & mask[1];
        bits.b = px.blue[plane] & mask[0];
        return bits;
    endfunction

    assign rd_addr   = {scan_pos.row, scan_pos.column};
    assign chan_mask = rgb_enable & {3{brightness_enable[scan_pos.plane]}};

    // updates two cycles into the low phase, well before the rising edge
    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            data_ready <= 1'b0;
            rgb_top    <= '0;
            rgb_bottom <= '0;
        end else begin
            data_ready <= shift_tick;
            if (data_ready) begin
                rgb_top    <= plane_bits(rd_data_top, scan_pos.plane, chan_mask);
                rgb_bottom <= plane_bits(rd_data_bottom, scan_pos.plane, chan_mask);
            end
        end
    end

endmodule

// File: rtl/led_matrix_pkg.sv
/* led matrix package
   panel sizes, command codes and the shared struct types of the HUB75 driver */
package led_matrix_pkg;

    // default sizes
    localparam int PANEL_WIDTH       = 16;
    localparam int PANEL_HALF_HEIGHT = 4;
    localparam int BRIGHTNESS_LEVELS = 4;

    // default timing in clk_root cycles or scan ticks
    localparam int UART_TICKS_PER_BIT = 4;
    localparam int SCAN_DIV           = 4;  // 4 at least
    localparam int BASE_DISPLAY_TICKS = 2;  // plane 0 on-time

    localparam int COL_W   = $clog2(PANEL_WIDTH);
    localparam int ROW_W   = $clog2(PANEL_HALF_HEIGHT);
    localparam int PLANE_W = $clog2(BRIGHTNESS_LEVELS);
    localparam int ADDR_W  = ROW_W + COL_W;  // one bank word per pixel

    // command bytes
    localparam logic [7:0] CMD_PIXEL        = 8'h50;
    localparam logic [7:0] CMD_RGB_ENABLE   = 8'h45;
    localparam logic [7:0] CMD_PLANE_ENABLE = 8'h4D;

    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } pixel_t;

    typedef struct packed {
        logic             valid;
        logic [ROW_W:0]   row;     // msb selects the bottom half
        logic [COL_W-1:0] column;
        pixel_t           pixel;
    } fb_write_t;

    typedef struct packed {
        logic [ROW_W-1:0]   row;
        logic [COL_W-1:0]   column;
        logic [PLANE_W-1:0] plane;
    } scan_pos_t;

    typedef struct packed {
        logic r;
        logic g;
        logic b;
    } rgb_t;

endpackage

// File: rtl/led_matrix_top.sv
/* led matrix top
   HUB75 driver for a 16x8 panel fed by UART commands */
`timescale 1ns/100ps
module led_matrix_top (
    input  logic                 clk_root,
    input  logic                 arst_n,
    input  logic                 uart_rxd,
    output led_matrix_pkg::rgb_t rgb_top,
    output led_matrix_pkg::rgb_t rgb_bottom,
    output logic                 pixel_clk,
    output logic                 row_latch,
    output logic                 oe_n,
    output logic [1:0]           row_addr
);
    import led_matrix_pkg::*;

    logic [7:0]                   rx_byte;
    logic                         rx_valid;
    fb_write_t                    fb_write;
    logic [2:0]                   rgb_enable;
    logic [BRIGHTNESS_LEVELS-1:0] brightness_enable;
    scan_pos_t                    scan_pos;
    logic                         shift_tick;
    logic [ADDR_W-1:0]            rd_addr;    // shared by both banks
    pixel_t                       rd_data_top;
    pixel_t                       rd_data_bottom;

    uart_rx #(
        .UART_TICKS_PER_BIT(UART_TICKS_PER_BIT)
    ) i_uart_rx (
        .clk_root(clk_root),
        .arst_n  (arst_n),
        .rx      (uart_rxd),
        .rx_byte (rx_byte),
        .rx_valid(rx_valid)
    );

    command_decoder #(
        .BRIGHTNESS_LEVELS(BRIGHTNESS_LEVELS)
    ) i_command_decoder (
        .clk_root         (clk_root),
        .arst_n           (arst_n),
        .rx_byte          (rx_byte),
        .rx_valid         (rx_valid),
        .fb_write         (fb_write),
        .rgb_enable       (rgb_enable),
        .brightness_enable(brightness_enable)
    );

    framebuffer_bank #(
        .BANK             (1'b0),
        .PANEL_WIDTH      (PANEL_WIDTH),
        .PANEL_HALF_HEIGHT(PANEL_HALF_HEIGHT)
    ) i_bank_top (
        .clk_root(clk_root),
        .fb_write(fb_write),
        .rd_addr (rd_addr),
        .rd_data (rd_data_top)
    );

    framebuffer_bank #(
        .BANK             (1'b1),
        .PANEL_WIDTH      (PANEL_WIDTH),
        .PANEL_HALF_HEIGHT(PANEL_HALF_HEIGHT)
    ) i_bank_bottom (
        .clk_root(clk_root),
        .fb_write(fb_write),
        .rd_addr (rd_addr),
        .rd_data (rd_data_bottom)
    );

    framebuffer_fetch #(
        .BRIGHTNESS_LEVELS(BRIGHTNESS_LEVELS)
    ) i_framebuffer_fetch (
        .clk_root         (clk_root),
        .arst_n           (arst_n),
        .scan_pos         (scan_pos),
        .shift_tick       (shift_tick),
        .rd_addr          (rd_addr),
        .rd_data_top      (rd_data_top),
        .rd_data_bottom   (rd_data_bottom),
        .rgb_enable       (rgb_enable),
        .brightness_enable(brightness_enable),
        .rgb_top          (rgb_top),
        .rgb_bottom       (rgb_bottom)
    );

    matrix_scan #(
        .PANEL_WIDTH       (PANEL_WIDTH),
        .PANEL_HALF_HEIGHT (PANEL_HALF_HEIGHT),
        .BRIGHTNESS_LEVELS (BRIGHTNESS_LEVELS),
        .SCAN_DIV          (SCAN_DIV),
        .BASE_DISPLAY_TICKS(BASE_DISPLAY_TICKS)
    ) i_matrix_scan (
        .clk_root  (clk_root),
        .arst_n    (arst_n),
        .scan_pos  (scan_pos),
        .shift_tick(shift_tick),
        .pixel_clk (pixel_clk),
        .row_latch (row_latch),
        .oe_n      (oe_n),
        .row_addr  (row_addr)
    );

endmodule

// File: rtl/matrix_scan.sv
/* matrix scan engine
   shifts columns, latches rows and times the output enable per bit plane */
`timescale 1ns/100ps
module matrix_scan #(
    parameter int PANEL_WIDTH        = led_matrix_pkg::PANEL_WIDTH,
    parameter int PANEL_HALF_HEIGHT  = led_matrix_pkg::PANEL_HALF_HEIGHT,
    parameter int BRIGHTNESS_LEVELS  = led_matrix_pkg::BRIGHTNESS_LEVELS,
    parameter int SCAN_DIV           = led_matrix_pkg::SCAN_DIV,
    parameter int BASE_DISPLAY_TICKS = led_matrix_pkg::BASE_DISPLAY_TICKS
) (
    input  logic                      clk_root,
    input  logic                      arst_n,
    output led_matrix_pkg::scan_pos_t scan_pos,
    output logic                      shift_tick,
    output logic                      pixel_clk,
    output logic                      row_latch,
    output logic                      oe_n,
    output logic [1:0]                row_addr
);
    import led_matrix_pkg::*;

    localparam int DIV_W    = $clog2(SCAN_DIV);
    localparam int DISP_MAX = BASE_DISPLAY_TICKS << (BRIGHTNESS_LEVELS - 1);
    localparam int DISP_W   = $clog2(DISP_MAX + 1);

    typedef enum logic [1:0] {ST_SHIFT_LO, ST_SHIFT_HI, ST_LATCH, ST_DISPLAY} scan_state_t;

    scan_state_t       state;
    logic [DIV_W-1:0]  div_cnt;
    logic              tick;     // one scan tick
    logic [DISP_W-1:0] disp_cnt; // ticks of on-time left
    logic              last_col;
    logic              last_plane;
    logic              last_row;

    assign tick       = (div_cnt == DIV_W'(SCAN_DIV - 1));
    assign last_col   = (scan_pos.column == COL_W'(PANEL_WIDTH - 1));
    assign last_plane = (scan_pos.plane == PLANE_W'(BRIGHTNESS_LEVELS - 1));
    assign last_row   = (scan_pos.row == ROW_W'(PANEL_HALF_HEIGHT - 1));
    assign shift_tick = (state == ST_SHIFT_LO) && (div_cnt == '0); // start of low phase

    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= tick ? '0 : div_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            state     <= ST_SHIFT_LO;
            scan_pos  <= '0;
            pixel_clk <= 1'b0;
            row_latch <= 1'b0;
            oe_n      <= 1'b1;
            row_addr  <= '0;
            disp_cnt  <= '0;
        end else if (tick) begin
            case (state)
                ST_SHIFT_LO: begin
                    pixel_clk <= 1'b1; // panel clocks the column in
                    state     <= ST_SHIFT_HI;
                end
                ST_SHIFT_HI: begin
                    pixel_clk <= 1'b0;
                    if (last_col) begin
                        row_latch <= 1'b1;
                        if (scan_pos.plane == '0) row_addr <= scan_pos.row;
                        state <= ST_LATCH;
                    end else begin
                        scan_pos.column <= scan_pos.column + 1'b1;
                        state           <= ST_SHIFT_LO;
                    end
                end
                ST_LATCH: begin
                    row_latch <= 1'b0;
                    oe_n      <= 1'b0;
                    // binary weighted on-time
                    disp_cnt  <= DISP_W'((BASE_DISPLAY_TICKS << scan_pos.plane) - 1);
                    state     <= ST_DISPLAY;
                end
                ST_DISPLAY: begin
                    if (disp_cnt == '0) begin
                        oe_n            <= 1'b1;
                        scan_pos.column <= '0;
                        state           <= ST_SHIFT_LO;
                        if (last_plane) begin
                            scan_pos.plane <= '0;
                            scan_pos.row   <= last_row ? '0 : scan_pos.row + 1'b1;
                        end else begin
                            scan_pos.plane <= scan_pos.plane + 1'b1;
                        end
                    end else begin
                        disp_cnt <= disp_cnt - 1'b1;
                    end
                end
                default: state <= ST_SHIFT_LO;
            endcase
        end
    end

endmodule

// File: rtl/uart_rx.sv
/* uart receiver
   8N1 frames sampled at the bit centre, one strobe per good byte */
`timescale 1ns/100ps
module uart_rx #(
    parameter int UART_TICKS_PER_BIT = led_matrix_pkg::UART_TICKS_PER_BIT
) (
    input  logic       clk_root,
    input  logic       arst_n,
    input  logic       rx,
    output logic [7:0] rx_byte,
    output logic       rx_valid
);
    localparam int CNT_W = $clog2(UART_TICKS_PER_BIT + 1);
    localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(UART_TICKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(UART_TICKS_PER_BIT / 2 - 1);

    typedef enum logic [1:0] {ST_IDLE, ST_START, ST_DATA, ST_STOP} rx_state_t;

    logic [1:0]       sync;      // sync[1] is safe to use
    rx_state_t        state;
    logic [CNT_W-1:0] tick_cnt;
    logic [2:0]       bit_cnt;
    logic             sample;

    // middle of start bit, then a full bit period each time
    assign sample = (state == ST_START) ? (tick_cnt == HALF_BIT) : (tick_cnt == FULL_BIT);

    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            sync <= 2'b11; // idle line is high
        end else begin
            sync <= {sync[0], rx};
        end
    end

    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            state    <= ST_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (state == ST_IDLE || sample) begin
                tick_cnt <= '0;
            end else begin
                tick_cnt <= tick_cnt + 1'b1;
            end
            case (state)
                ST_IDLE: if (!sync[1]) state <= ST_START;
                ST_START: begin
                    bit_cnt <= '0;
                    if (sample) state <= sync[1] ? ST_IDLE : ST_DATA; // high again is a glitch
                end
                ST_DATA: begin
                    if (sample) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) state <= ST_STOP;
                    end
                end
                ST_STOP: begin
                    if (sample) begin
                        rx_valid <= sync[1]; // framing error drops the byte
                        state    <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // lsb arrives first
    always_ff @(posedge clk_root) begin
        if (state == ST_DATA && sample) rx_byte <= {sync[1], rx_byte[7:1]};
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# compile and run the led matrix testbench with verilator
# exit status is 0 only when the log holds the pass line

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --timescale 1ns/100ps \
    --top-module tb_led_matrix -f verilog.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_led_matrix > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -qx "STATUS: PASS" "$log"; then
    exit 0
fi
exit 1

// File: sim/tb_clock_gen.sv
/* testbench clock and reset
   40 ns clk_root, arst_n held low for the first cycles */
`timescale 1ns/100ps
module tb_clock_gen #(
    parameter int HALF_PERIOD  = 20,
    parameter int RESET_CYCLES = 4
) (
    output logic clk_root,
    output logic arst_n
);

    initial begin
        clk_root = 1'b0;
        forever #(HALF_PERIOD) clk_root = ~clk_root;
    end

    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_root);
        arst_n <= 1'b1; // released on a rising edge
    end

endmodule

// File: sim/tb_led_matrix.sv
/* led matrix testbench
   sends UART commands to the HUB75 driver and checks the panel pins against a pixel model */
`timescale 1ns/100ps
module tb_led_matrix;
    import led_matrix_pkg::*;

    localparam int LINE_W       = 3 * PANEL_WIDTH;        // rgb bits of one shifted line
    localparam int FULL_ROWS    = 2 * PANEL_HALF_HEIGHT;
    localparam int FRAME_CHECKS = 5;
    localparam int UART_BYTES   = 4 * PANEL_WIDTH * FULL_ROWS + 14; // fill plus settings and strays
    localparam int FRAME_CYCLES = PANEL_HALF_HEIGHT * SCAN_DIV * (BRIGHTNESS_LEVELS
        * (2 * PANEL_WIDTH + 1) + BASE_DISPLAY_TICKS * ((1 << BRIGHTNESS_LEVELS) - 1));
    localparam int WATCHDOG_CYCLES = 2 * (UART_BYTES * 10 * UART_TICKS_PER_BIT
        + 3 * FRAME_CHECKS * FRAME_CYCLES);
    localparam logic [31:0] SEED = 32'h1c6a7110;

    logic       clk_root;
    logic       arst_n;
    logic       uart_rxd;
    rgb_t       rgb_top;
    rgb_t       rgb_bottom;
    logic       pixel_clk;
    logic       row_latch;
    logic       oe_n;
    logic [1:0] row_addr;

    // reference model
    logic [11:0]                  model_fb [FULL_ROWS][PANEL_WIDTH];
    logic [2:0]                   model_rgb_en;
    logic [BRIGHTNESS_LEVELS-1:0] model_plane_en;

    // monitor results
    logic              pclk_q, latch_q, oe_q;
    logic [LINE_W-1:0] cap_top, cap_bottom, line_top, line_bottom;
    int col_idx, line_cols, line_row, line_plane, latch_count;
    int oe_low, oe_len, oe_plane, oe_count, overlap_count;

    string cur_test = "startup";
    int    error_count = 0;
    int    check_count = 0;
    int    test_count = 0;

    tb_clock_gen i_clock_gen (.clk_root(clk_root), .arst_n(arst_n));

    led_matrix_top i_led_matrix_top (
        .clk_root  (clk_root),
        .arst_n    (arst_n),
        .uart_rxd  (uart_rxd),
        .rgb_top   (rgb_top),
        .rgb_bottom(rgb_bottom),
        .pixel_clk (pixel_clk),
        .row_latch (row_latch),
        .oe_n      (oe_n),
        .row_addr  (row_addr)
    );

    // panel monitor samples the pins on clk_root where they are settled
    always @(posedge clk_root) begin
        if (!arst_n) begin
            pclk_q        = 1'b0;
            latch_q       = 1'b0;
            oe_q          = 1'b1;
            col_idx       = 0;
            latch_count   = 0;
            oe_count      = 0;
            overlap_count = 0;
        end else begin
            if (pixel_clk && !pclk_q) begin
                if (col_idx < PANEL_WIDTH) begin
                    cap_top[col_idx*3 +: 3]    = rgb_top;
                    cap_bottom[col_idx*3 +: 3] = rgb_bottom;
                end
                col_idx++;
            end
            if (row_latch && !latch_q) begin
                line_top    = cap_top;
                line_bottom = cap_bottom;
                line_cols   = col_idx;
                line_row    = int'(row_addr); // row_addr moves with the latch
                line_plane  = latch_count % BRIGHTNESS_LEVELS;
                col_idx     = 0;
                latch_count++;
            end
            if (!oe_n && pixel_clk != pclk_q) overlap_count++;
            if (!oe_n && oe_q) begin
                oe_plane = line_plane;
                oe_low   = 0;
            end
            if (!oe_n) oe_low++;
            if (oe_n && !oe_q) begin
                oe_len = oe_low;
                oe_count++;
            end
            pclk_q  = pixel_clk;
            latch_q = row_latch;
            oe_q    = oe_n;
        end
    end

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERROR %s: %s expected %0h, actual %0h", cur_test, what, expected, actual);
        end
    endtask

    task automatic report_test(input int start_errors);
        test_count++;
        $display("%-18s %s", cur_test, (error_count == start_errors) ? "ok" : "failed");
    endtask

    // 8N1, lsb first
    task automatic send_byte(input logic [7:0] value);
        logic [9:0] frame;
        frame = {1'b1, value, 1'b0};
        @(posedge clk_root);
        for (int i = 0; i < 10; i++) begin
            uart_rxd <= frame[i];
            repeat (UART_TICKS_PER_BIT) @(posedge clk_root);
        end
    endtask

    task automatic write_pixel(input int row, input int col, input logic [11:0] px);
        send_byte(CMD_PIXEL);
        send_byte({1'b0, 3'(row), 4'(col)});
        send_byte({4'h0, px[11:8]});
        send_byte(px[7:0]);
        model_fb[row][col] = px;
    endtask

    task automatic set_rgb_enable(input logic [2:0] enable);
        send_byte(CMD_RGB_ENABLE);
        send_byte({5'b0, enable});
        model_rgb_en = enable;
    endtask

    task automatic set_plane_enable(input logic [BRIGHTNESS_LEVELS-1:0] enable);
        send_byte(CMD_PLANE_ENABLE);
        send_byte(8'(enable));
        model_plane_en = enable;
    endtask

    task automatic await_latch();
        int seen;
        seen = latch_count;
        wait (latch_count != seen);
    endtask

    task automatic await_display();
        int seen;
        seen = oe_count;
        wait (oe_count != seen);
    endtask

    // returns at the latch of the last row's last plane
    task automatic sync_to_frame();
        repeat (8) @(posedge clk_root); // last write still on its way
        do
            await_latch();
        while (line_row != PANEL_HALF_HEIGHT - 1 || line_plane != BRIGHTNESS_LEVELS - 1);
    endtask

    // bit of the plane, gated by channel and plane enable
    function automatic logic [LINE_W-1:0] expected_line(int row, int plane, int half);
        logic [LINE_W-1:0] bits;
        logic [11:0]       px;
        for (int c = 0; c < PANEL_WIDTH; c++) begin
            px = model_fb[row + half * PANEL_HALF_HEIGHT][c];
            bits[c*3 +: 3] = {px[8 + plane] & model_rgb_en[2], px[4 + plane] & model_rgb_en[1],
                              px[plane] & model_rgb_en[0]} & {3{model_plane_en[plane]}};
        end
        return bits;
    endfunction

    task automatic compare_frame();
        int row;
        int plane;
        sync_to_frame();
        for (int n = 0; n < PANEL_HALF_HEIGHT * BRIGHTNESS_LEVELS; n++) begin
            row   = n / BRIGHTNESS_LEVELS;
            plane = n % BRIGHTNESS_LEVELS;
            await_latch();
            check_value("row_addr at latch", 64'(row), 64'(line_row));
            check_value("columns shifted", 64'(PANEL_WIDTH), 64'(line_cols));
            check_value($sformatf("top row %0d plane %0d", row, plane),
                        64'(expected_line(row, plane, 0)), 64'(line_top));
            check_value($sformatf("bottom row %0d plane %0d", row, plane),
                        64'(expected_line(row, plane, 1)), 64'(line_bottom));
        end
    endtask

    task automatic reset_state_test();
        int start_errors;
        start_errors = error_count;
        cur_test = "reset_state";
        @(posedge clk_root); // reset values are in place after the first edge
        @(posedge clk_root);
        while (!arst_n) begin
            check_value("oe_n in reset", 64'(1), 64'(oe_n));
            check_value("pixel_clk in reset", 64'(0), 64'(pixel_clk));
            check_value("row_latch in reset", 64'(0), 64'(row_latch));
            @(posedge clk_root);
        end
        check_value("oe_n after reset", 64'(1), 64'(oe_n));
        check_value("pixel_clk after reset", 64'(0), 64'(pixel_clk));
        check_value("row_latch after reset", 64'(0), 64'(row_latch));
        await_latch();
        check_value("first latch row_addr", 64'(0), 64'(line_row));
        report_test(start_errors);
    endtask

    task automatic full_frame_test();
        int start_errors;
        start_errors = error_count;
        cur_test = "full_frame";
        for (int r = 0; r < FULL_ROWS; r++) begin
            for (int c = 0; c < PANEL_WIDTH; c++) write_pixel(r, c, 12'($urandom()));
        end
        compare_frame();
        report_test(start_errors);
    endtask

    task automatic channel_enable_test();
        int start_errors;
        start_errors = error_count;
        cur_test = "channel_enable";
        set_rgb_enable(3'b101); // green off
        compare_frame();
        set_rgb_enable(3'b111);
        report_test(start_errors);
    endtask

    task automatic plane_enable_test();
        int start_errors;
        start_errors = error_count;
        cur_test = "plane_enable";
        set_plane_enable(4'b1000);
        compare_frame();
        set_plane_enable(4'b1111);
        report_test(start_errors);
    endtask

    task automatic modulation_timing_test();
        int start_errors;
        int plane;
        start_errors = error_count;
        cur_test = "modulation_timing";
        sync_to_frame();
        for (int n = 0; n < PANEL_HALF_HEIGHT * BRIGHTNESS_LEVELS; n++) begin
            plane = (n + BRIGHTNESS_LEVELS - 1) % BRIGHTNESS_LEVELS; // first one ends the frame
            await_display();
            check_value("display plane", 64'(plane), 64'(oe_plane));
            check_value($sformatf("oe_n low cycles, plane %0d", plane),
                        64'((BASE_DISPLAY_TICKS << plane) * SCAN_DIV), 64'(oe_len));
        end
        check_value("oe_n low while pixel_clk toggles", 64'(0), 64'(overlap_count));
        report_test(start_errors);
    endtask

    task automatic stray_byte_test();
        int start_errors;
        int row;
        int col;
        start_errors = error_count;
        cur_test = "stray_bytes";
        row = $urandom_range(FULL_ROWS - 1);
        col = $urandom_range(PANEL_WIDTH - 1);
        send_byte(8'h00);
        send_byte(8'hFF);
        write_pixel(row, col, ~model_fb[row][col]); // every bit flips
        compare_frame();
        report_test(start_errors);
    endtask

    initial begin
        uart_rxd       = 1'b1; // idle line
        model_rgb_en   = 3'b111;
        model_plane_en = '1;
        void'($urandom(SEED));
        reset_state_test();
        full_frame_test();
        channel_enable_test();
        plane_enable_test();
        modulation_timing_test();
        stray_byte_test();
        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // UART traffic plus three frames per frame check, doubled
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_root);
        $display("timeout after %0d cycles, %s did not finish", WATCHDOG_CYCLES, cur_test);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// File: verilog.f
rtl/led_matrix_pkg.sv
rtl/uart_rx.sv
rtl/command_decoder.sv
rtl/framebuffer_bank.sv
rtl/framebuffer_fetch.sv
rtl/matrix_scan.sv
rtl/led_matrix_top.sv
sim/tb_clock_gen.sv
sim/tb_led_matrix.sv
